//--- logic/uart_pkg.sv
package uart_pkg;

  // Character and bus widths
  localparam int DATA_W = 8;
  typedef logic [DATA_W-1:0] data_t;

  localparam int BAUD_W = 16;
  typedef logic [BAUD_W-1:0] baud_div_t;

  localparam int FRAC_W = 8;
  typedef logic [FRAC_W-1:0] baud_frac_t;

  localparam int OVERSAMPLE = 16;  // Ticks per bit
  typedef logic [$clog2(OVERSAMPLE)-1:0] tick_cnt_t;

  typedef logic [31:0] reg_word_t;

  // --------------------
  // Register map
  typedef enum logic [7:0] {
    REG_DATA   = 8'h00,
    REG_STATUS = 8'h04,
    REG_CTRL   = 8'h08,
    REG_BAUD   = 8'h0C,
    REG_ISR    = 8'h10,
    REG_IMR    = 8'h14,
    REG_FCR    = 8'h18
  } reg_addr_e;

  // Code 1 is treated as no parity
  typedef enum logic [1:0] {
    PAR_NONE = 2'd0,
    PAR_EVEN = 2'd2,
    PAR_ODD  = 2'd3
  } parity_e;

  typedef enum logic [1:0] {TX_IDLE, TX_SEND} tx_state_e;

  typedef enum logic [2:0] {
    RX_IDLE, RX_START, RX_DATA, RX_PARITY, RX_STOP, RX_DONE
  } rx_state_e;

  // --------------------
  // Field positions
  localparam int CTRL_TX_EN = 0;
  localparam int CTRL_RX_EN = 1;
  localparam int CTRL_TWO_STOP = 4;
  localparam int CTRL_PARITY_LSB = 6;  // 2-bit field
  localparam int CTRL_LOOPBACK = 9;

  localparam int ST_RX_AVAIL = 0;
  localparam int ST_TX_EMPTY = 1;
  localparam int ST_TX_BUSY = 4;
  localparam int ST_PARITY_ERR = 6;
  localparam int ST_STOP_ERR = 7;
  localparam int ST_RX_FULL = 8;
  localparam int ST_TX_FULL = 9;

  localparam int ISR_RX = 0;
  localparam int ISR_TX_EMPTY = 1;
  localparam int ISR_OVERRUN = 2;
  localparam int ISR_FRAME_ERR = 3;

  localparam int FCR_TX_FLUSH = 0;
  localparam int FCR_RX_FLUSH = 1;

  localparam reg_word_t REG_UNMAPPED = 32'hDEAD_BEEF;

endpackage

//--- logic/uart_fifo.sv
module uart_fifo #(
  parameter int DEPTH = 8
) (
  input  logic            clk,
  input  logic            rst_n,
  input  logic            flush,
  input  logic            wr_valid,
  input  uart_pkg::data_t wr_data,
  output logic            wr_ready,
  output logic            rd_valid,
  output uart_pkg::data_t rd_data,
  input  logic            rd_ready,
  output logic            full
);
  import uart_pkg::*;

  localparam int AW = $clog2(DEPTH);

  data_t       mem [DEPTH];
  logic [AW:0] wr_ptr;
  logic [AW:0] rd_ptr;  // Extra MSB tells full from empty
  logic        empty;
  logic        push;
  logic        pop;

  assign empty = (wr_ptr == rd_ptr);
  assign full  = (wr_ptr[AW] != rd_ptr[AW]) && (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);

  assign wr_ready = !full;
  assign rd_valid = !empty;
  assign rd_data  = mem[rd_ptr[AW-1:0]];  // Head shown before the pop

  assign push = wr_valid && !full;
  assign pop  = rd_ready && !empty;

  // --------------------
  // Pointers
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else if (flush) begin
      // Drops everything, including a push in the same cycle
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
    end
  end

  // Storage
  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr[AW-1:0]] <= wr_data;
    end
  end

endmodule

//--- logic/uart_baud_gen.sv
module uart_baud_gen (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 run,
  input  uart_pkg::baud_div_t  baud_div,
  input  uart_pkg::baud_frac_t baud_frac,
  output logic                 tick
);
  import uart_pkg::*;

  baud_div_t       cnt;
  baud_frac_t      frac_cnt;
  logic            stretch;
  logic [BAUD_W:0] span;    // Cycles in the current tick period
  logic            at_end;

  // Long periods are spread over every group of 256 ticks
  assign stretch = (frac_cnt < baud_frac);
  assign span    = {1'b0, baud_div} + {{BAUD_W{1'b0}}, stretch};
  assign at_end  = ({1'b0, cnt} + {{BAUD_W{1'b0}}, 1'b1}) >= span;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cnt      <= '0;
      frac_cnt <= '0;
      tick     <= 1'b0;
    end else if (!run) begin
      // Engine idle
      cnt      <= '0;
      frac_cnt <= '0;
      tick     <= 1'b0;
    end else begin
      tick <= 1'b0;
      if (baud_div != '0) begin  // Zero divisor stops the ticks
        if (at_end) begin
          cnt      <= '0;
          tick     <= 1'b1;
          frac_cnt <= frac_cnt + 1'b1;  // Wraps at 256
        end else begin
          cnt <= cnt + 1'b1;
        end
      end
    end
  end

endmodule

//--- logic/uart_tx.sv
module uart_tx (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              tx_en,
  input  uart_pkg::parity_e parity,
  input  logic              two_stop,
  input  logic              tick,
  input  logic              data_valid,
  input  uart_pkg::data_t   data,
  output logic              data_ready,
  output logic              run,
  output logic              tx_busy,
  output logic              txd
);
  import uart_pkg::*;

  localparam int SHIFT_W = DATA_W + 3;  // Data, parity, two stops
  localparam tick_cnt_t LAST_TICK = tick_cnt_t'(OVERSAMPLE - 1);

  tx_state_e          state;
  logic [SHIFT_W-1:0] shifter;
  logic [3:0]         bits_left;
  logic [3:0]         frame_bits;
  tick_cnt_t          tick_cnt;
  logic               par_en;
  logic               par_bit;
  logic               start;
  logic               bit_end;

  assign par_en  = (parity == PAR_EVEN) || (parity == PAR_ODD);
  assign par_bit = ^data ^ (parity == PAR_ODD);
  // Bits that follow the start bit
  assign frame_bits = 4'(DATA_W) + {3'b0, par_en} + 4'd1 + {3'b0, two_stop};

  assign start   = (state == TX_IDLE) && tx_en && data_valid;
  assign bit_end = tick && (tick_cnt == LAST_TICK);
  assign run     = (state != TX_IDLE);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state      <= TX_IDLE;
      txd        <= 1'b1;
      tx_busy    <= 1'b0;
      data_ready <= 1'b0;
      tick_cnt   <= '0;
      bits_left  <= '0;
    end else begin
      data_ready <= 1'b0;
      case (state)
        TX_IDLE: begin
          txd     <= 1'b1;
          tx_busy <= 1'b0;
          if (start) begin
            state      <= TX_SEND;
            tx_busy    <= 1'b1;
            txd        <= 1'b0;  // Start bit
            data_ready <= 1'b1;  // Pops the FIFO head
            tick_cnt   <= '0;
            bits_left  <= frame_bits;
          end
        end
        TX_SEND: begin
          if (tick) begin
            tick_cnt <= tick_cnt + 1'b1;
          end
          if (bit_end) begin
            if (bits_left == '0) begin  // Last stop bit done
              state   <= TX_IDLE;
              tx_busy <= 1'b0;
              txd     <= 1'b1;
            end else begin
              txd       <= shifter[0];
              bits_left <= bits_left - 1'b1;
            end
          end
        end
        default: state <= TX_IDLE;
      endcase
    end
  end

  // Frame payload, LSB first
  always_ff @(posedge clk) begin
    if (start) begin
      shifter <= par_en ? {2'b11, par_bit, data} : {3'b111, data};
    end else if (state == TX_SEND && bit_end) begin
      shifter <= {1'b1, shifter[SHIFT_W-1:1]};
    end
  end

endmodule

//--- logic/uart_rx.sv
module uart_rx (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              rx_en,
  input  logic              loopback,
  input  uart_pkg::parity_e parity,
  input  logic              two_stop,
  input  logic              rxd,
  input  logic              txd,
  input  logic              tick,
  output logic              run,
  output logic              data_valid,
  output uart_pkg::data_t   data,
  output logic              parity_err,
  output logic              stop_err
);
  import uart_pkg::*;

  localparam tick_cnt_t LAST_TICK = tick_cnt_t'(OVERSAMPLE - 1);
  localparam tick_cnt_t MID_TICK = tick_cnt_t'(OVERSAMPLE / 2 - 1);
  localparam logic [2:0] LAST_BIT = 3'(DATA_W - 1);

  rx_state_e  state;
  logic [1:0] rxd_sync;
  logic       line;
  tick_cnt_t  tick_cnt;
  logic [2:0] bit_cnt;
  data_t      shifter;
  logic       par_bit;     // Received parity bit
  logic       par_en;
  logic       expect_par;
  logic       bit_end;

  // Two-flop synchronizer for the pin
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rxd_sync <= 2'b11;
    end else begin
      rxd_sync <= {rxd_sync[0], rxd};
    end
  end

  assign line       = loopback ? txd : rxd_sync[1];
  assign par_en     = (parity == PAR_EVEN) || (parity == PAR_ODD);
  assign expect_par = ^shifter ^ (parity == PAR_ODD);
  assign bit_end    = tick && (tick_cnt == LAST_TICK);

  assign run        = (state != RX_IDLE);
  assign data_valid = (state == RX_DONE);  // One cycle per frame
  assign data       = shifter;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state      <= RX_IDLE;
      tick_cnt   <= '0;
      bit_cnt    <= '0;
      parity_err <= 1'b0;
      stop_err   <= 1'b0;
    end else begin
      if (tick) begin
        tick_cnt <= tick_cnt + 1'b1;  // Wraps once per bit
      end
      case (state)
        RX_IDLE: begin
          tick_cnt <= '0;
          if (rx_en && !line) begin
            state <= RX_START;
          end
        end
        RX_START: begin
          // Recheck the line half a bit into the start bit
          if (tick && tick_cnt == MID_TICK) begin
            tick_cnt <= '0;
            bit_cnt  <= '0;
            state    <= line ? RX_IDLE : RX_DATA;
          end
        end
        RX_DATA: begin
          if (bit_end) begin
            bit_cnt <= bit_cnt + 1'b1;  // Back to 0 after the last bit
            if (bit_cnt == LAST_BIT) begin
              state <= par_en ? RX_PARITY : RX_STOP;
            end
          end
        end
        RX_PARITY: begin
          if (bit_end) begin
            state <= RX_STOP;
          end
        end
        RX_STOP: begin
          if (bit_end) begin
            if (line && two_stop && bit_cnt == '0) begin
              bit_cnt <= 3'd1;  // Second stop bit follows
            end else begin
              state      <= RX_DONE;
              stop_err   <= !line;
              parity_err <= par_en && (par_bit != expect_par);
            end
          end
        end
        RX_DONE: state <= RX_IDLE;
        default: state <= RX_IDLE;
      endcase
    end
  end

  // Payload sampling at bit centers
  always_ff @(posedge clk) begin
    if (state == RX_DATA && bit_end) begin
      shifter <= {line, shifter[DATA_W-1:1]};
    end
    if (state == RX_PARITY && bit_end) begin
      par_bit <= line;
    end
  end

endmodule

//--- logic/uart_regs.sv
module uart_regs #(
  parameter uart_pkg::baud_div_t DEFAULT_BAUD_DIV = 16'd4
) (
  input  logic                 clk,
  input  logic                 rst_n,
  input  uart_pkg::reg_addr_e  reg_addr,
  input  uart_pkg::reg_word_t  reg_wdata,
  input  logic                 reg_we,
  input  logic                 reg_re,
  output uart_pkg::reg_word_t  reg_rdata,
  // Transmit FIFO
  output logic                 tx_wr_valid,
  output uart_pkg::data_t      tx_wr_data,
  input  logic                 tx_wr_ready,
  input  logic                 tx_rd_valid,
  input  logic                 tx_full,
  // Receive FIFO
  input  logic                 rx_rd_valid,
  input  uart_pkg::data_t      rx_rd_data,
  output logic                 rx_rd_ready,
  input  logic                 rx_full,
  input  logic                 rx_wr_valid,
  input  logic                 rx_wr_ready,
  // Engine status
  input  logic                 tx_busy,
  input  logic                 parity_err,
  input  logic                 stop_err,
  // Configuration
  output logic                 tx_en,
  output logic                 rx_en,
  output logic                 two_stop,
  output logic                 loopback,
  output uart_pkg::parity_e    parity,
  output uart_pkg::baud_div_t  baud_div,
  output uart_pkg::baud_frac_t baud_frac,
  output logic                 tx_flush,
  output logic                 rx_flush,
  output logic                 intr
);
  import uart_pkg::*;

  reg_word_t  ctrl;
  reg_word_t  imr;
  reg_word_t  status;
  logic [3:0] isr;
  logic [3:0] isr_set;
  logic [3:0] isr_clr;
  logic [1:0] fcr;         // Flush bits, cleared the next cycle
  logic       tx_empty;
  logic       tx_empty_q;

  // --------------------
  // FIFO access strobes
  assign tx_wr_valid = reg_we && (reg_addr == REG_DATA) && tx_wr_ready;  // Full drops it
  assign tx_wr_data  = reg_wdata[DATA_W-1:0];
  assign rx_rd_ready = reg_re && (reg_addr == REG_DATA);

  assign tx_en    = ctrl[CTRL_TX_EN];
  assign rx_en    = ctrl[CTRL_RX_EN];
  assign two_stop = ctrl[CTRL_TWO_STOP];
  assign loopback = ctrl[CTRL_LOOPBACK];
  assign parity   = parity_e'(ctrl[CTRL_PARITY_LSB +: 2]);
  assign tx_flush = fcr[FCR_TX_FLUSH];
  assign rx_flush = fcr[FCR_RX_FLUSH];

  assign tx_empty = !tx_rd_valid;

  // Interrupt sources
  always_comb begin
    isr_set                = '0;
    isr_set[ISR_RX]        = rx_rd_valid;
    isr_set[ISR_TX_EMPTY]  = tx_empty && !tx_empty_q;  // Only on the drain edge
    isr_set[ISR_OVERRUN]   = rx_wr_valid && !rx_wr_ready;
    isr_set[ISR_FRAME_ERR] = rx_wr_valid && rx_wr_ready && (parity_err || stop_err);
  end

  assign isr_clr = (reg_we && reg_addr == REG_ISR) ? reg_wdata[3:0] : 4'b0;
  assign intr    = |(isr & imr[3:0]);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ctrl       <= '0;
      baud_div   <= DEFAULT_BAUD_DIV;
      baud_frac  <= '0;
      imr        <= '0;
      isr        <= '0;
      fcr        <= '0;
      tx_empty_q <= 1'b1;
    end else begin
      fcr        <= '0;
      tx_empty_q <= tx_empty;
      isr        <= (isr & ~isr_clr) | isr_set;  // New events win over a clear
      if (reg_we) begin
        case (reg_addr)
          REG_CTRL: ctrl <= reg_wdata;
          REG_BAUD: begin
            baud_div  <= reg_wdata[BAUD_W-1:0];
            baud_frac <= reg_wdata[BAUD_W +: FRAC_W];
          end
          REG_IMR: imr <= reg_wdata;
          REG_FCR: fcr <= reg_wdata[1:0];
          default: ;
        endcase
      end
    end
  end

  // --------------------
  // Read side
  always_comb begin
    status                = '0;
    status[ST_RX_AVAIL]   = rx_rd_valid;
    status[ST_TX_EMPTY]   = tx_empty;
    status[ST_TX_BUSY]    = tx_busy;
    status[ST_PARITY_ERR] = parity_err;
    status[ST_STOP_ERR]   = stop_err;
    status[ST_RX_FULL]    = rx_full;
    status[ST_TX_FULL]    = tx_full;
  end

  always_comb begin
    case (reg_addr)
      REG_DATA:   reg_rdata = reg_word_t'(rx_rd_data);
      REG_STATUS: reg_rdata = status;
      REG_CTRL:   reg_rdata = ctrl;
      REG_BAUD:   reg_rdata = reg_word_t'({baud_frac, baud_div});
      REG_ISR:    reg_rdata = reg_word_t'(isr);
      REG_IMR:    reg_rdata = imr;
      REG_FCR:    reg_rdata = reg_word_t'(fcr);
      default:    reg_rdata = REG_UNMAPPED;
    endcase
  end

endmodule

//--- logic/uart_core.sv
module uart_core #(
  parameter int                  FIFO_DEPTH       = 8,
  parameter uart_pkg::baud_div_t DEFAULT_BAUD_DIV = 16'd4
) (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                uart_rxd,
  output logic                uart_txd,
  input  uart_pkg::reg_addr_e reg_addr,
  input  uart_pkg::reg_word_t reg_wdata,
  input  logic                reg_we,
  input  logic                reg_re,
  output uart_pkg::reg_word_t reg_rdata,
  output logic                intr
);
  import uart_pkg::*;

  // Transmit path
  logic       tx_wr_valid, tx_wr_ready, tx_rd_valid, tx_rd_ready, tx_full;
  data_t      tx_wr_data, tx_rd_data;
  logic       tx_run, tx_tick, tx_busy, tx_flush;
  // Receive path
  logic       rx_wr_valid, rx_wr_ready, rx_rd_valid, rx_rd_ready, rx_full;
  data_t      rx_wr_data, rx_rd_data;
  logic       rx_run, rx_tick, rx_flush, parity_err, stop_err;
  // Configuration
  logic       tx_en, rx_en, two_stop, loopback;
  parity_e    parity;
  baud_div_t  baud_div;
  baud_frac_t baud_frac;

  uart_regs #(.DEFAULT_BAUD_DIV(DEFAULT_BAUD_DIV)) u_regs (.*);

  uart_fifo #(.DEPTH(FIFO_DEPTH)) u_tx_fifo (
    .clk, .rst_n, .flush(tx_flush), .wr_valid(tx_wr_valid), .wr_data(tx_wr_data),
    .wr_ready(tx_wr_ready), .rd_valid(tx_rd_valid), .rd_data(tx_rd_data),
    .rd_ready(tx_rd_ready), .full(tx_full)
  );

  uart_fifo #(.DEPTH(FIFO_DEPTH)) u_rx_fifo (
    .clk, .rst_n, .flush(rx_flush), .wr_valid(rx_wr_valid), .wr_data(rx_wr_data),
    .wr_ready(rx_wr_ready), .rd_valid(rx_rd_valid), .rd_data(rx_rd_data),
    .rd_ready(rx_rd_ready), .full(rx_full)
  );

  uart_baud_gen u_tx_baud (.clk, .rst_n, .run(tx_run), .baud_div, .baud_frac, .tick(tx_tick));
  uart_baud_gen u_rx_baud (.clk, .rst_n, .run(rx_run), .baud_div, .baud_frac, .tick(rx_tick));

  uart_tx u_tx (
    .clk, .rst_n, .tx_en, .parity, .two_stop, .tick(tx_tick),
    .data_valid(tx_rd_valid), .data(tx_rd_data), .data_ready(tx_rd_ready),
    .run(tx_run), .tx_busy, .txd(uart_txd)
  );

  // Loopback taps the transmit line inside the receiver
  uart_rx u_rx (
    .clk, .rst_n, .rx_en, .loopback, .parity, .two_stop, .rxd(uart_rxd), .txd(uart_txd),
    .tick(rx_tick), .run(rx_run), .data_valid(rx_wr_valid), .data(rx_wr_data),
    .parity_err, .stop_err
  );

endmodule

//--- tests/uart_core_properties.sv
module uart_tx_properties (
  input logic clk,
  input logic rst_n,
  input logic txd,
  input logic tx_busy,
  input logic data_ready,
  input logic data_valid
);

  // Idle line stays at the mark level
  property idle_line_high;
    @(posedge clk) disable iff (!rst_n) !tx_busy |-> txd;
  endproperty

  property ready_with_valid;
    @(posedge clk) disable iff (!rst_n) data_ready |-> data_valid;
  endproperty

  property ready_single_pulse;
    @(posedge clk) disable iff (!rst_n) data_ready |=> !data_ready;
  endproperty

  a_idle_line_high: assert property (idle_line_high)
    else $error("txd low while the transmitter is not busy");
  a_ready_with_valid: assert property (ready_with_valid)
    else $error("data_ready without data_valid");
  a_ready_single_pulse: assert property (ready_single_pulse)
    else $error("data_ready high for two cycles");

endmodule

bind uart_tx uart_tx_properties u_props (
  .clk, .rst_n, .txd, .tx_busy, .data_ready, .data_valid
);

//--- tests/uart_core_tb.sv
module uart_core_tb;
  import uart_pkg::*;

  localparam int FIFO_DEPTH = 8;
  localparam int DIV = 4;
  localparam int BIT_CYC = OVERSAMPLE * DIV;
  localparam int NUM_FRAMES = 29;
  localparam int TIMEOUT_CYCLES = NUM_FRAMES * 12 * 16 * DIV * 2 + 2000;

  logic      clk;
  logic      rst_n;
  logic      uart_rxd;
  logic      uart_txd;
  reg_addr_e reg_addr;
  reg_word_t reg_wdata;
  logic      reg_we;
  logic      reg_re;
  reg_word_t reg_rdata;
  logic      intr;

  integer      seed;
  int          errors;
  int          tests_run;
  int          tests_ok;
  int          test_start_err;
  int          cycles;
  string       cur_test;
  logic        mon_en;
  parity_e     cur_par;
  logic        cur_two_stop;
  data_t       exp_q[$];
  logic [11:0] mon_q[$];

  uart_core #(.FIFO_DEPTH(FIFO_DEPTH), .DEFAULT_BAUD_DIV(16'(DIV))) u_dut (.*);

  always #20 clk = !clk;

  // --------------------
  // Reference and checks
  // Bit 0 is the start bit and unused top bits stay at the stop level
  function automatic logic [11:0] ref_frame(uart_pkg::data_t d, uart_pkg::parity_e p);
    logic [11:0] f;
    f = '1;
    f[0] = 1'b0;
    f[8:1] = d;
    if (p == PAR_EVEN) f[9] = ^d;
    else if (p == PAR_ODD) f[9] = ~^d;
    return f;
  endfunction

  task automatic check_data(string name, uart_pkg::data_t exp, uart_pkg::data_t act);
    if (exp !== act) begin
      errors++;
      $display("MISMATCH %s %s: expected %h, actual %h", cur_test, name, exp, act);
    end
  endtask

  task automatic check_reg(string name, uart_pkg::reg_word_t exp, uart_pkg::reg_word_t act);
    if (exp !== act) begin
      errors++;
      $display("MISMATCH %s %s: expected %h, actual %h", cur_test, name, exp, act);
    end
  endtask

  task automatic check_bit(string name, logic exp, logic act);
    if (exp !== act) begin
      errors++;
      $display("MISMATCH %s %s: expected %b, actual %b", cur_test, name, exp, act);
    end
  endtask

  task automatic begin_test(string name);
    cur_test = name;
    test_start_err = errors;
  endtask

  task automatic end_test();
    tests_run++;
    if (errors == test_start_err) begin
      tests_ok++;
      $display("test %s: ok", cur_test);
    end else begin
      $display("test %s: FAILED with %0d errors", cur_test, errors - test_start_err);
    end
  endtask

  // --------------------
  // Bus access
  task automatic reg_write(uart_pkg::reg_addr_e a, uart_pkg::reg_word_t d);
    @(negedge clk);
    reg_addr = a;
    reg_wdata = d;
    reg_we = 1'b1;
    @(negedge clk);
    reg_we = 1'b0;
  endtask

  task automatic reg_read(uart_pkg::reg_addr_e a, output uart_pkg::reg_word_t d);
    @(negedge clk);
    reg_addr = a;
    reg_re = 1'b1;
    #1 d = reg_rdata;  // Combinational read settles within the cycle
    @(negedge clk);
    reg_re = 1'b0;
  endtask

  task automatic wait_rx_avail();
    reg_word_t st;
    st = '0;
    while (!st[ST_RX_AVAIL]) reg_read(REG_STATUS, st);
  endtask

  task automatic wait_tx_idle();
    reg_word_t st;
    st = '0;
    st[ST_TX_BUSY] = 1'b1;
    while (st[ST_TX_BUSY] || !st[ST_TX_EMPTY]) reg_read(REG_STATUS, st);
  endtask

  // Line model for uart_rxd
  task automatic send_frame(uart_pkg::data_t d, uart_pkg::parity_e p, logic two_stop,
                            logic bad_par, logic bad_stop);
    logic [11:0] f;
    int          nb;
    int          par_en;
    f = ref_frame(d, p);
    par_en = (p == PAR_EVEN || p == PAR_ODD) ? 1 : 0;
    nb = 10 + par_en + int'(two_stop);
    if (bad_par) f[9] = !f[9];
    if (bad_stop) f[9 + par_en] = 1'b0;
    for (int i = 0; i < nb; i++) begin
      @(negedge clk);
      uart_rxd = f[i];
      repeat (BIT_CYC - 1) @(negedge clk);
    end
    @(negedge clk);
    uart_rxd = 1'b1;
  endtask

  // Monitor on uart_txd that samples at bit centers
  initial begin
    logic [11:0] f;
    int          nb;
    forever begin
      @(negedge uart_txd);
      if (mon_en) begin
        f = '1;
        nb = 10 + ((cur_par == PAR_EVEN || cur_par == PAR_ODD) ? 1 : 0) + int'(cur_two_stop);
        repeat (BIT_CYC / 2) @(negedge clk);
        for (int i = 0; i < nb; i++) begin
          f[i] = uart_txd;
          if (i < nb - 1) repeat (BIT_CYC) @(negedge clk);
        end
        mon_q.push_back(f);
      end
    end
  end

  // Compares monitored frames with the expected bytes
  initial begin
    logic [11:0] f;
    data_t       d;
    forever begin
      @(negedge clk);
      if (mon_q.size() > 0) begin
        f = mon_q.pop_front();
        if (exp_q.size() == 0) begin
          errors++;
          $display("%s: a frame appeared on uart_txd with no byte expected", cur_test);
        end else begin
          d = exp_q.pop_front();
          check_reg("frame", reg_word_t'(ref_frame(d, cur_par)), reg_word_t'(f));
        end
      end
    end
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("run stopped after %0d cycles without finishing", cycles);
      $display("tests failed");
      $finish;
    end
  end

  // --------------------
  // Test sequence
  initial begin
    reg_word_t rd;
    data_t     bytes[$];
    data_t     d;
    parity_e   pars[3];
    logic      stops[3];
    clk = 1'b0;
    rst_n = 1'b0;
    uart_rxd = 1'b1;
    reg_addr = REG_DATA;
    reg_wdata = '0;
    reg_we = 1'b0;
    reg_re = 1'b0;
    seed = 32'h00b78e95;
    errors = 0;
    tests_run = 0;
    tests_ok = 0;
    cycles = 0;
    mon_en = 1'b0;
    cur_par = PAR_NONE;
    cur_two_stop = 1'b0;
    repeat (2) @(negedge clk);
    rst_n = 1'b1;

    begin_test("reset_regs");
    reg_read(REG_CTRL, rd);
    check_reg("ctrl", 32'h0, rd);
    reg_read(REG_BAUD, rd);
    check_reg("baud", 32'(DIV), rd);
    reg_read(REG_ISR, rd);
    check_reg("isr", 32'h0, rd);
    reg_read(reg_addr_e'(8'h20), rd);
    check_reg("unmapped", REG_UNMAPPED, rd);
    check_bit("uart_txd", 1'b1, uart_txd);
    check_bit("intr", 1'b0, intr);
    reg_write(REG_IMR, 32'h5A5A_0004);
    reg_read(REG_IMR, rd);
    check_reg("imr", 32'h5A5A_0004, rd);
    end_test();

    begin_test("transmit");
    pars = '{PAR_EVEN, PAR_ODD, PAR_NONE};
    stops = '{1'b0, 1'b1, 1'b0};
    mon_en = 1'b1;
    for (int c = 0; c < 3; c++) begin
      cur_par = pars[c];
      cur_two_stop = stops[c];
      reg_write(REG_CTRL, (32'(pars[c]) << CTRL_PARITY_LSB) | (32'(stops[c]) << CTRL_TWO_STOP) |
                          (32'h1 << CTRL_TX_EN));
      for (int i = 0; i < 3; i++) begin
        d = data_t'($random(seed));
        exp_q.push_back(d);
        reg_write(REG_DATA, 32'(d));
      end
      while (exp_q.size() != 0) @(negedge clk);
      wait_tx_idle();
    end
    mon_en = 1'b0;
    end_test();

    begin_test("receive_errors");
    reg_write(REG_CTRL, (32'(PAR_EVEN) << CTRL_PARITY_LSB) | (32'h1 << CTRL_RX_EN));
    reg_write(REG_ISR, 32'hF);
    bytes.delete();
    for (int i = 0; i < 2; i++) begin
      bytes.push_back(data_t'($random(seed)));
      send_frame(bytes[i], PAR_EVEN, 1'b0, 1'b0, 1'b0);
    end
    for (int i = 0; i < 2; i++) begin
      wait_rx_avail();
      reg_read(REG_DATA, rd);
      check_data("rx byte", bytes[i], data_t'(rd));
    end
    d = data_t'($random(seed));
    send_frame(d, PAR_EVEN, 1'b0, 1'b1, 1'b0);  // Wrong parity bit
    wait_rx_avail();
    reg_read(REG_STATUS, rd);
    check_bit("parity_err", 1'b1, rd[ST_PARITY_ERR]);
    reg_read(REG_ISR, rd);
    check_bit("isr frame_err", 1'b1, rd[ISR_FRAME_ERR]);
    reg_read(REG_DATA, rd);
    check_data("bad parity byte", d, data_t'(rd));
    d = data_t'($random(seed));
    send_frame(d, PAR_EVEN, 1'b0, 1'b0, 1'b1);  // Low stop bit
    wait_rx_avail();
    reg_read(REG_STATUS, rd);
    check_bit("stop_err", 1'b1, rd[ST_STOP_ERR]);
    reg_read(REG_DATA, rd);
    check_data("bad stop byte", d, data_t'(rd));
    end_test();

    begin_test("loopback_frac");
    reg_write(REG_BAUD, (32'd128 << BAUD_W) | 32'(DIV));
    reg_write(REG_CTRL, (32'h1 << CTRL_TX_EN) | (32'h1 << CTRL_RX_EN) |
                        (32'h1 << CTRL_TWO_STOP) | (32'h1 << CTRL_LOOPBACK));
    bytes.delete();
    for (int i = 0; i < 4; i++) begin
      bytes.push_back(data_t'($random(seed)));
      reg_write(REG_DATA, 32'(bytes[i]));
    end
    for (int i = 0; i < 4; i++) begin
      wait_rx_avail();
      reg_read(REG_DATA, rd);
      check_data("loopback byte", bytes[i], data_t'(rd));
    end
    wait_tx_idle();
    reg_write(REG_BAUD, 32'(DIV));
    end_test();

    begin_test("overrun_intr");
    reg_write(REG_CTRL, 32'h1 << CTRL_RX_EN);
    reg_write(REG_ISR, 32'hF);
    reg_write(REG_IMR, 32'h1 << ISR_OVERRUN);
    bytes.delete();
    for (int i = 0; i < FIFO_DEPTH + 2; i++) begin
      bytes.push_back(data_t'($random(seed)));
      send_frame(bytes[i], PAR_NONE, 1'b0, 1'b0, 1'b0);
    end
    reg_read(REG_ISR, rd);
    check_bit("isr overrun", 1'b1, rd[ISR_OVERRUN]);
    check_bit("intr", 1'b1, intr);
    reg_write(REG_ISR, 32'h1 << ISR_OVERRUN);
    reg_read(REG_ISR, rd);
    check_bit("isr overrun cleared", 1'b0, rd[ISR_OVERRUN]);
    for (int i = 0; i < FIFO_DEPTH; i++) begin
      reg_read(REG_DATA, rd);
      check_data("kept byte", bytes[i], data_t'(rd));
    end
    reg_read(REG_STATUS, rd);
    check_bit("rx_avail after drain", 1'b0, rd[ST_RX_AVAIL]);
    end_test();

    begin_test("flush");
    send_frame(data_t'($random(seed)), PAR_NONE, 1'b0, 1'b0, 1'b0);
    wait_rx_avail();
    reg_write(REG_FCR, 32'h1 << FCR_RX_FLUSH);
    reg_read(REG_STATUS, rd);
    check_bit("rx_avail after flush", 1'b0, rd[ST_RX_AVAIL]);
    d = data_t'($random(seed));
    send_frame(d, PAR_NONE, 1'b0, 1'b0, 1'b0);
    wait_rx_avail();
    reg_read(REG_DATA, rd);
    check_data("byte after flush", d, data_t'(rd));
    reg_read(REG_STATUS, rd);
    check_bit("rx_avail at end", 1'b0, rd[ST_RX_AVAIL]);
    end_test();

    $display("%0d of %0d tests ok, %0d errors", tests_ok, tests_run, errors);
    if (errors == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

//--- all.f
logic/uart_pkg.sv
logic/uart_fifo.sv
logic/uart_baud_gen.sv
logic/uart_tx.sv
logic/uart_rx.sv
logic/uart_regs.sv
logic/uart_core.sv
tests/uart_core_properties.sv
tests/uart_core_tb.sv

//--- run.sh
#!/bin/sh
# Build and run the UART testbench with Verilator
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -f all.f --top-module uart_core_tb -o uart_sim &&
./obj_dir/uart_sim | tee /dev/stderr | grep -q "all tests passed" &&
echo "PASS" ||
{ echo "FAIL"; exit 1; }
